/* src.f */
lc4_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_alu.sv
lc4_stage_reg.sv
lc4_hazard_unit.sv
lc4_branch_unit.sv
lc4_processor.sv
lc4_processor_assert.sv
tb_lc4_processor.sv

/* Bender.yml */
package:
  name: lc4_processor

sources:
  - lc4_pkg.sv
  - lc4_decoder.sv
  - lc4_regfile.sv
  - lc4_alu.sv
  - lc4_stage_reg.sv
  - lc4_hazard_unit.sv
  - lc4_branch_unit.sv
  - lc4_processor.sv
  - target: test
    files:
      - lc4_processor_assert.sv
      - tb_lc4_processor.sv

/* tb_lc4_processor.sv */
// LC4 pipeline testbench
// Program and data memories, a sequential reference interpreter and
// directed plus LFSR-built programs checked against the commit trace
// and the store requests
`timescale 1ns/10ps

module tb_lc4_processor;

   localparam int CLK_PERIOD      = 4;
   localparam int RESET_CYCLES    = 8;
   localparam int NUM_TESTS       = 5;
   localparam int CYCLES_PER_TEST = 200;
   localparam int COMMIT_TIMEOUT  = 16;

   logic                 clk;
   logic                 i_arst_n;
   lc4_pkg::word_t       o_pc;
   lc4_pkg::word_t       i_insn;
   lc4_pkg::dmem_req_t   o_dmem;
   lc4_pkg::word_t       i_dmem_rdata;
   lc4_pkg::commit_t     o_commit;

   // Memories for the DUT and the interpreter
   lc4_pkg::word_t       imem    [0:65535];
   lc4_pkg::word_t       dmem    [0:65535];
   lc4_pkg::word_t       ref_mem [0:65535];
   lc4_pkg::word_t       ref_regs [lc4_pkg::NUM_REGS];
   lc4_pkg::nzp_t        ref_nzp;

   lc4_pkg::word_t       prog[$];
   lc4_pkg::commit_t     exp_commits[$];
   lc4_pkg::dmem_req_t   exp_stores[$];

   logic [31:0]          lfsr_state;
   int                   errors;
   int                   checks;
   int                   tests_run;
   int                   tests_failed;

   lc4_processor UUT (
      .clk(clk), .i_arst_n(i_arst_n), .o_pc(o_pc), .i_insn(i_insn),
      .o_dmem(o_dmem), .i_dmem_rdata(i_dmem_rdata), .o_commit(o_commit));

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Same-cycle memory answers
   assign i_insn       = imem[o_pc];
   assign i_dmem_rdata = dmem[o_dmem.addr];

   always @(posedge clk) begin
      if (o_dmem.we) begin
         dmem[o_dmem.addr] <= o_dmem.wdata;
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[14:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Background data that depends on every address bit
   function automatic lc4_pkg::word_t fill_word(input lc4_pkg::word_t a);
      return {a[7:0] ^ 8'h3c, a[15:8] ^ 8'ha5};
   endfunction

   function automatic lc4_pkg::word_t sext(input lc4_pkg::word_t v, input int bits);
      lc4_pkg::word_t m;
      lc4_pkg::word_t f;
      m = lc4_pkg::word_t'(1) << (bits - 1);
      f = v & ((m << 1) - 16'd1);
      return (f ^ m) - m;
   endfunction

   // Sign of the value read as a two's complement word
   function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t v);
      lc4_pkg::nzp_t c;
      c.n = ($signed(v) < 0);
      c.z = ($signed(v) == 0);
      c.p = ($signed(v) > 0);
      return c;
   endfunction

   // Instruction encoders
   function automatic lc4_pkg::word_t add_insn(input lc4_pkg::reg_idx_t rd,
         input lc4_pkg::reg_idx_t rs, input lc4_pkg::reg_idx_t rt);
      return {lc4_pkg::OP_ADD, rd, rs, 3'b000, rt};
   endfunction

   function automatic lc4_pkg::word_t addi_insn(input lc4_pkg::reg_idx_t rd,
         input lc4_pkg::reg_idx_t rs, input logic [4:0] imm5);
      return {lc4_pkg::OP_ADD, rd, rs, 1'b1, imm5};
   endfunction

   function automatic lc4_pkg::word_t const_insn(input lc4_pkg::reg_idx_t rd,
         input logic [8:0] imm9);
      return {lc4_pkg::OP_CONST, rd, imm9};
   endfunction

   function automatic lc4_pkg::word_t ldr_insn(input lc4_pkg::reg_idx_t rd,
         input lc4_pkg::reg_idx_t rs, input logic [5:0] imm6);
      return {lc4_pkg::OP_LDR, rd, rs, imm6};
   endfunction

   function automatic lc4_pkg::word_t str_insn(input lc4_pkg::reg_idx_t rt,
         input lc4_pkg::reg_idx_t rs, input logic [5:0] imm6);
      return {lc4_pkg::OP_STR, rt, rs, imm6};
   endfunction

   function automatic lc4_pkg::word_t br_insn(input logic [2:0] mask, input logic [8:0] imm9);
      return {lc4_pkg::OP_BR, mask, imm9};
   endfunction

   task automatic compare_pc(input lc4_pkg::word_t got, input lc4_pkg::word_t exp,
         input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Register and NZP fields only count where the matching enable is set
   task automatic compare_commit(input lc4_pkg::commit_t got, input lc4_pkg::commit_t exp,
         input string what);
      logic bad;
      checks++;
      bad = (got.valid !== exp.valid);
      if (exp.valid) begin
         if (got.pc !== exp.pc || got.insn !== exp.insn) bad = 1'b1;
         if (got.rd_we !== exp.rd_we || got.nzp_we !== exp.nzp_we) bad = 1'b1;
         if (exp.rd_we && (got.rd !== exp.rd || got.rd_data !== exp.rd_data)) bad = 1'b1;
         if (exp.nzp_we && got.nzp !== exp.nzp) bad = 1'b1;
      end
      if (bad) begin
         errors++;
         $display("Fail %0t: %s got valid %b pc %h insn %h rd_we %b r%0d=%h nzp_we %b nzp %b",
                  $time, what, got.valid, got.pc, got.insn, got.rd_we, got.rd, got.rd_data,
                  got.nzp_we, got.nzp);
         $display("     expected valid %b pc %h insn %h rd_we %b r%0d=%h nzp_we %b nzp %b",
                  exp.valid, exp.pc, exp.insn, exp.rd_we, exp.rd, exp.rd_data,
                  exp.nzp_we, exp.nzp);
      end
   endtask

   task automatic compare_dmem(input lc4_pkg::dmem_req_t got, input lc4_pkg::dmem_req_t exp,
         input string what);
      checks++;
      if (got.we !== exp.we ||
          (exp.we && (got.addr !== exp.addr || got.wdata !== exp.wdata))) begin
         errors++;
         $display("Fail %0t: %s got we %b [%h]=%h, expected we %b [%h]=%h", $time, what,
                  got.we, got.addr, got.wdata, exp.we, exp.addr, exp.wdata);
      end
   endtask

   task automatic compare_cycle(input int got, input int exp, input string what);
      checks++;
      if (got != exp) begin
         errors++;
         $display("Fail %0t: %s is cycle %0d, expected cycle %0d", $time, what, got, exp);
      end
   endtask

   // Sequential LC4 semantics for n retired instructions from RESET_PC
   task automatic ref_run(input int n);
      lc4_pkg::word_t     pc;
      lc4_pkg::word_t     insn;
      lc4_pkg::word_t     addr;
      lc4_pkg::word_t     val;
      lc4_pkg::reg_idx_t  rd;
      lc4_pkg::reg_idx_t  rs;
      lc4_pkg::reg_idx_t  rt;
      logic [3:0]         op;
      lc4_pkg::commit_t   c;
      lc4_pkg::dmem_req_t st;
      pc = lc4_pkg::RESET_PC;
      ref_nzp = '0;
      exp_commits.delete();
      exp_stores.delete();
      for (int r = 0; r < lc4_pkg::NUM_REGS; r++) ref_regs[r] = '0;
      for (int k = 0; k < n; k++) begin
         insn = imem[pc];
         op = insn[15:12];
         rd = insn[11:9];
         rs = insn[8:6];
         rt = insn[2:0];
         val = '0;
         c = '0;
         c.valid = 1'b1;
         c.pc = pc;
         c.insn = insn;
         if (op == lc4_pkg::OP_ADD && (insn[5] || insn[4:3] == 2'b00)) begin
            val = insn[5] ? ref_regs[rs] + sext(insn, 5) : ref_regs[rs] + ref_regs[rt];
            c.rd_we = 1'b1;
            c.nzp_we = 1'b1;
         end else if (op == lc4_pkg::OP_CONST) begin
            val = sext(insn, 9);
            c.rd_we = 1'b1;
            c.nzp_we = 1'b1;
         end else if (op == lc4_pkg::OP_LDR) begin
            addr = ref_regs[rs] + sext(insn, 6);
            val = ref_mem[addr];
            c.rd_we = 1'b1;
         end else if (op == lc4_pkg::OP_STR) begin
            // Data register sits in bits 11:9
            addr = ref_regs[rs] + sext(insn, 6);
            ref_mem[addr] = ref_regs[rd];
            st.we = 1'b1;
            st.addr = addr;
            st.wdata = ref_regs[rd];
            exp_stores.push_back(st);
         end
         if (c.rd_we) begin
            c.rd = rd;
            c.rd_data = val;
            ref_regs[rd] = val;
         end
         if (c.nzp_we) begin
            c.nzp = nzp_of(val);
            ref_nzp = c.nzp;
         end
         exp_commits.push_back(c);
         if (op == lc4_pkg::OP_BR && |(insn[11:9] & ref_nzp)) pc = pc + 16'd1 + sext(insn, 9);
         else pc = pc + 16'd1;
      end
   endtask

   task automatic apply_reset();
      lc4_pkg::commit_t   idle_commit;
      lc4_pkg::dmem_req_t idle_req;
      idle_commit = '0;
      idle_req = '0;
      @(posedge clk);
      #1;
      i_arst_n = 1'b0;
      repeat (RESET_CYCLES) begin
         @(negedge clk);
         compare_pc(o_pc, lc4_pkg::RESET_PC, "PC during reset");
         compare_commit(o_commit, idle_commit, "commit during reset");
         compare_dmem(o_dmem, idle_req, "dmem request during reset");
      end
   endtask

   // Reset, load prog, release and check n commits plus their stores
   task automatic run_program(input int n, output int first_commit, output int first_store);
      int seen;
      int idle;
      int cycle;
      lc4_pkg::dmem_req_t got_stores[$];
      apply_reset();
      for (int a = 0; a < 65536; a++) begin
         imem[a] = '0;
         dmem[a] = fill_word(lc4_pkg::word_t'(a));
         ref_mem[a] = dmem[a];
      end
      foreach (prog[i]) imem[lc4_pkg::RESET_PC + i] = prog[i];
      ref_run(n);
      @(posedge clk);
      #1;
      i_arst_n = 1'b1;
      seen = 0;
      idle = 0;
      cycle = 0;
      first_commit = -1;
      first_store = -1;
      while (seen < n && idle < COMMIT_TIMEOUT) begin
         @(negedge clk);
         if (cycle == 0) compare_pc(o_pc, lc4_pkg::RESET_PC, "PC right after reset");
         if (o_commit.valid) begin
            if (first_commit < 0) first_commit = cycle;
            compare_commit(o_commit, exp_commits[seen], $sformatf("commit %0d", seen));
            seen++;
            idle = 0;
         end else begin
            idle++;
         end
         // A store in Memory belongs to an instruction younger than all commits so far
         if (o_dmem.we && seen < n) begin
            if (first_store < 0) first_store = cycle;
            got_stores.push_back(o_dmem);
         end
         cycle++;
      end
      if (seen < n) begin
         errors++;
         $display("%0t: no commit for %0d cycles, only %0d of %0d instructions retired",
                  $time, COMMIT_TIMEOUT, seen, n);
      end
      if (got_stores.size() != exp_stores.size()) begin
         errors++;
         $display("%0t: DUT issued %0d stores where %0d were expected", $time,
                  got_stores.size(), exp_stores.size());
      end
      for (int i = 0; i < got_stores.size() && i < exp_stores.size(); i++) begin
         compare_dmem(got_stores[i], exp_stores[i], $sformatf("store %0d", i));
      end
   endtask

   task automatic report_test(input string name, input int start_errors);
      tests_run++;
      if (errors == start_errors) begin
         $display("%0t  %s: ok", $time, name);
      end else begin
         tests_failed++;
         $display("%0t  %s: failed with %0d errors", $time, name, errors - start_errors);
      end
   endtask

   // Store first, so its request shows the 3-cycle Fetch to Memory latency
   task automatic test_reset();
      int start;
      int fc;
      int fs;
      start = errors;
      prog.delete();
      prog.push_back(str_insn(3'd0, 3'd0, 6'sd5));
      prog.push_back(const_insn(3'd1, 9'sd7));
      prog.push_back(add_insn(3'd2, 3'd1, 3'd1));
      run_program(4, fc, fs);
      compare_cycle(fc, 4, "first commit");
      compare_cycle(fs, 3, "first store request");
      report_test("reset state", start);
   endtask

   // Memory, Writeback and register-file bypasses
   task automatic test_dependency_chain();
      int start;
      int fc;
      int fs;
      start = errors;
      prog.delete();
      prog.push_back(const_insn(3'd1, 9'sd5));
      prog.push_back(add_insn(3'd2, 3'd1, 3'd1));
      prog.push_back(add_insn(3'd3, 3'd2, 3'd1));
      prog.push_back(addi_insn(3'd4, 3'd1, -5'sd3));
      prog.push_back(add_insn(3'd5, 3'd3, 3'd2));
      prog.push_back(const_insn(3'd6, -9'sd200));
      prog.push_back(add_insn(3'd7, 3'd6, 3'd5));
      prog.push_back(addi_insn(3'd1, 3'd7, 5'sd15));
      run_program(8, fc, fs);
      report_test("dependency chain", start);
   endtask

   // Load-use on rs and rt alone and together
   task automatic test_store_load();
      int start;
      int fc;
      int fs;
      start = errors;
      prog.delete();
      prog.push_back(const_insn(3'd2, 9'sd100));
      prog.push_back(const_insn(3'd1, -9'sd77));
      prog.push_back(str_insn(3'd1, 3'd2, 6'sd3));
      prog.push_back(ldr_insn(3'd3, 3'd2, 6'sd3));
      prog.push_back(add_insn(3'd4, 3'd3, 3'd3));
      prog.push_back(ldr_insn(3'd5, 3'd2, -6'sd5));
      prog.push_back(add_insn(3'd6, 3'd0, 3'd5));
      prog.push_back(ldr_insn(3'd7, 3'd2, 6'sd3));
      prog.push_back(addi_insn(3'd7, 3'd7, 5'sd1));
      prog.push_back(str_insn(3'd6, 3'd7, 6'sd0));
      run_program(10, fc, fs);
      report_test("store, load and load-use", start);
   endtask

   // Every mask taken and not taken plus one backward loop of two passes
   task automatic test_branches();
      int start;
      int fc;
      int fs;
      start = errors;
      prog.delete();
      prog.push_back(const_insn(3'd1, 9'sd0));
      prog.push_back(br_insn(3'b100, 9'sd2));
      prog.push_back(br_insn(3'b010, 9'sd2));
      prog.push_back(const_insn(3'd7, 9'sd1));
      prog.push_back(const_insn(3'd7, 9'sd2));
      prog.push_back(const_insn(3'd1, -9'sd4));
      prog.push_back(br_insn(3'b001, 9'sd1));
      prog.push_back(br_insn(3'b100, 9'sd2));
      prog.push_back(addi_insn(3'd7, 3'd7, 5'sd1));
      prog.push_back(addi_insn(3'd7, 3'd7, 5'sd2));
      prog.push_back(addi_insn(3'd1, 3'd1, 5'sd5));
      prog.push_back(br_insn(3'b101, 9'sd1));
      prog.push_back(const_insn(3'd7, 9'sd3));
      prog.push_back(br_insn(3'b111, 9'sd2));
      prog.push_back(const_insn(3'd7, 9'sd4));
      prog.push_back(const_insn(3'd7, 9'sd5));
      prog.push_back(br_insn(3'b000, 9'sd3));
      prog.push_back(addi_insn(3'd2, 3'd1, -5'sd1));
      prog.push_back(br_insn(3'b011, 9'sd1));
      prog.push_back(const_insn(3'd7, 9'sd6));
      prog.push_back(const_insn(3'd3, 9'sd9));
      prog.push_back(br_insn(3'b001, 9'sd0));
      prog.push_back(add_insn(3'd4, 3'd3, 3'd3));
      prog.push_back(addi_insn(3'd5, 3'd5, 5'sd1));
      prog.push_back(addi_insn(3'd6, 3'd5, -5'sd2));
      prog.push_back(br_insn(3'b100, -9'sd3));
      run_program(22, fc, fs);
      report_test("branches", start);
   endtask

   // Forward-only branch offsets keep the programs from looping in place
   task automatic build_random(input int len);
      logic [2:0]        kind;
      lc4_pkg::reg_idx_t rd;
      lc4_pkg::reg_idx_t rs;
      lc4_pkg::reg_idx_t rt;
      prog.delete();
      for (int k = 0; k < len; k++) begin
         kind = 3'(rand_bits(3));
         rd = 3'(rand_bits(3));
         rs = 3'(rand_bits(3));
         rt = 3'(rand_bits(3));
         case (kind)
            3'd1:       prog.push_back(addi_insn(rd, rs, 5'(rand_bits(5))));
            3'd2, 3'd3: prog.push_back(const_insn(rd, 9'(rand_bits(9))));
            3'd4:       prog.push_back(ldr_insn(rd, rs, 6'(rand_bits(6))));
            3'd5:       prog.push_back(str_insn(rd, rs, 6'(rand_bits(6))));
            3'd6:       prog.push_back(br_insn(3'(rand_bits(3)), 9'(rand_bits(2))));
            default:    prog.push_back(add_insn(rd, rs, rt));
         endcase
      end
   endtask

   task automatic test_random_programs();
      int start;
      int fc;
      int fs;
      start = errors;
      for (int r = 0; r < 2; r++) begin
         build_random(48);
         run_program(40, fc, fs);
      end
      report_test("random programs", start);
   endtask

   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the tests did not complete",
               NUM_TESTS * CYCLES_PER_TEST);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      i_arst_n = 1'b0;
      lfsr_state = 32'h572c;
      errors = 0;
      checks = 0;
      tests_run = 0;
      tests_failed = 0;
      test_reset();
      test_dependency_chain();
      test_store_load();
      test_branches();
      test_random_programs();
      if (UUT.u_assert.fail_count != 0) begin
         errors += UUT.u_assert.fail_count;
         $display("%0d pipeline assertions fired", UUT.u_assert.fail_count);
      end
      $display("Tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
               checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* lc4_processor_assert.sv */
// LC4 pipeline control checks
// Bound into the core, watches reset, stall versus flush and the
// two slots squashed behind a taken branch
`timescale 1ns/10ps

module lc4_processor_assert (
   input logic clk,
   input logic i_arst_n,
   input logic i_dmem_we,
   input logic i_stall,
   input logic i_flush,
   input logic i_taken,
   input logic i_commit_valid
);

   int unsigned fail_count = 0;

   // Memory latch still holds a bubble straight out of reset
   a_no_store_after_reset: assert property (
      @(posedge clk) $rose(i_arst_n) |-> !i_dmem_we ##1 !i_dmem_we)
      else begin
         $error("store request right after reset release");
         fail_count++;
      end

   // Taken branch already squashes the load consumer
   a_stall_flush_exclusive: assert property (
      @(posedge clk) disable iff (!i_arst_n) !(i_stall && i_flush))
      else begin
         $error("stall and flush asserted in the same cycle");
         fail_count++;
      end

   // Branch commits two cycles on, its two younger slots are bubbles
   a_no_commit_after_taken: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      i_taken |-> ##3 !i_commit_valid ##1 !i_commit_valid)
      else begin
         $error("flushed instruction committed after a taken branch");
         fail_count++;
      end

endmodule

bind lc4_processor lc4_processor_assert u_assert (
   .clk(clk),
   .i_arst_n(i_arst_n),
   .i_dmem_we(o_dmem.we),
   .i_stall(stall),
   .i_flush(flush),
   .i_taken(taken),
   .i_commit_valid(o_commit.valid)
);

/* lc4_processor.sv */
// LC4 five-stage pipelined core
// Fetch, Decode, Execute, Memory and Writeback with full bypassing,
// one-bubble load-use stall and not-taken prediction resolved in Execute.
// Emits a commit record for every retired instruction
`timescale 1ns/10ps

module lc4_processor (
   input  logic               clk,
   input  logic               i_arst_n,
   output lc4_pkg::word_t     o_pc,
   input  lc4_pkg::word_t     i_insn,
   output lc4_pkg::dmem_req_t o_dmem,
   input  lc4_pkg::word_t     i_dmem_rdata,
   output lc4_pkg::commit_t   o_commit
);

   lc4_pkg::word_t    pc;
   lc4_pkg::fd_t      fd_d, fd_q;
   lc4_pkg::dx_t      dx_d, dx_q;
   lc4_pkg::xm_t      xm_d, xm_q;
   lc4_pkg::mw_t      mw_d, mw_q;
   lc4_pkg::ctrl_t    dec_ctrl, d_ctrl;
   lc4_pkg::word_t    d_rs_data, d_rt_data;
   lc4_pkg::word_t    x_a, x_b, x_result, w_data;
   lc4_pkg::fwd_sel_t fwd_a, fwd_b;
   lc4_pkg::nzp_t     x_nzp;
   logic              stall, flush, taken;

   // Fetch
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc <= lc4_pkg::RESET_PC;
      end else if (taken) begin
         pc <= x_result;
      end else if (!stall) begin
         pc <= pc + 16'd1;
      end
   end
   assign o_pc = pc;
   assign fd_d = '{valid: 1'b1, pc: pc, insn: i_insn};

   lc4_stage_reg #(.T_PAYLOAD(lc4_pkg::fd_t)) u_fd (
      .clk(clk), .i_arst_n(i_arst_n), .i_hold(stall), .i_flush(flush), .i_d(fd_d), .o_q(fd_q));

   // Decode, a flushed slot decodes to a bubble
   lc4_decoder u_dec (.i_insn(fd_q.insn), .o_ctrl(dec_ctrl));
   assign d_ctrl = fd_q.valid ? dec_ctrl : '0;

   lc4_regfile u_rf (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_rs(d_ctrl.rs), .i_rt(d_ctrl.rt), .o_rs_data(d_rs_data), .o_rt_data(d_rt_data),
      .i_rd(mw_q.ctrl.rd), .i_rd_we(mw_q.ctrl.rd_we), .i_rd_data(w_data));

   assign dx_d = '{pc: fd_q.pc, insn: fd_q.insn, ctrl: d_ctrl,
                   rs_data: d_rs_data, rt_data: d_rt_data};

   // Bubble in on load-use or taken branch
   lc4_stage_reg #(.T_PAYLOAD(lc4_pkg::dx_t)) u_dx (
      .clk(clk), .i_arst_n(i_arst_n), .i_hold(1'b0), .i_flush(stall | flush),
      .i_d(dx_d), .o_q(dx_q));

   lc4_hazard_unit u_haz (
      .i_d_ctrl(d_ctrl), .i_x_ctrl(dx_q.ctrl), .i_m_ctrl(xm_q.ctrl), .i_w_ctrl(mw_q.ctrl),
      .i_taken(taken), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_stall(stall), .o_flush(flush));

   // Execute bypass muxes
   assign x_a = (fwd_a == lc4_pkg::FWD_M) ? xm_q.result :
                (fwd_a == lc4_pkg::FWD_W) ? w_data : dx_q.rs_data;
   assign x_b = (fwd_b == lc4_pkg::FWD_M) ? xm_q.result :
                (fwd_b == lc4_pkg::FWD_W) ? w_data : dx_q.rt_data;

   lc4_alu u_alu (
      .i_insn(dx_q.insn), .i_pc(dx_q.pc), .i_a(x_a), .i_b(x_b), .o_result(x_result));

   lc4_branch_unit u_br (
      .clk(clk), .i_arst_n(i_arst_n), .i_x_ctrl(dx_q.ctrl), .i_x_insn(dx_q.insn),
      .i_x_result(x_result), .o_nzp(x_nzp), .o_taken(taken));

   // Store data rides along as the forwarded rt value
   assign xm_d = '{pc: dx_q.pc, insn: dx_q.insn, ctrl: dx_q.ctrl,
                   result: x_result, st_data: x_b, nzp: x_nzp};

   lc4_stage_reg #(.T_PAYLOAD(lc4_pkg::xm_t)) u_xm (
      .clk(clk), .i_arst_n(i_arst_n), .i_hold(1'b0), .i_flush(1'b0), .i_d(xm_d), .o_q(xm_q));

   // Memory, address only meaningful for loads and stores
   assign o_dmem.we    = xm_q.ctrl.valid && xm_q.ctrl.is_store;
   assign o_dmem.addr  = (xm_q.ctrl.is_load || xm_q.ctrl.is_store) ? xm_q.result : '0;
   assign o_dmem.wdata = xm_q.st_data;

   assign mw_d = '{pc: xm_q.pc, insn: xm_q.insn, ctrl: xm_q.ctrl, result: xm_q.result,
                   st_data: xm_q.st_data, nzp: xm_q.nzp, ld_data: i_dmem_rdata};

   lc4_stage_reg #(.T_PAYLOAD(lc4_pkg::mw_t)) u_mw (
      .clk(clk), .i_arst_n(i_arst_n), .i_hold(1'b0), .i_flush(1'b0), .i_d(mw_d), .o_q(mw_q));

   // Writeback
   assign w_data = mw_q.ctrl.is_load ? mw_q.ld_data : mw_q.result;

   assign o_commit = '{valid: mw_q.ctrl.valid, pc: mw_q.pc, insn: mw_q.insn,
                       rd_we: mw_q.ctrl.rd_we, rd: mw_q.ctrl.rd, rd_data: w_data,
                       nzp_we: mw_q.ctrl.nzp_we, nzp: mw_q.nzp};

endmodule

/* lc4_branch_unit.sv */
// LC4 condition codes and branch resolution
// Keeps the NZP register and decides taken for a branch in Execute
`timescale 1ns/10ps

module lc4_branch_unit (
   input  logic           clk,
   input  logic           i_arst_n,
   input  lc4_pkg::ctrl_t i_x_ctrl,
   input  lc4_pkg::word_t i_x_insn,
   input  lc4_pkg::word_t i_x_result,
   output lc4_pkg::nzp_t  o_nzp,
   output logic           o_taken
);

   lc4_pkg::nzp_t nzp_q;

   // Sign classification of the Execute result
   assign o_nzp.n = i_x_result[15];
   assign o_nzp.z = (i_x_result == '0);
   assign o_nzp.p = !i_x_result[15] && (i_x_result != '0);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         nzp_q <= '0;
      end else if (i_x_ctrl.valid && i_x_ctrl.nzp_we) begin
         nzp_q <= o_nzp;
      end
   end

   // Mask bits 11:9 line up with n, z, p
   assign o_taken = i_x_ctrl.valid && i_x_ctrl.is_branch && |(i_x_insn[11:9] & nzp_q);

endmodule

/* lc4_hazard_unit.sv */
// LC4 hazard control
// Chooses Execute operand sources, detects load-use and flushes on a taken
// branch
`timescale 1ns/10ps

module lc4_hazard_unit (
   input  lc4_pkg::ctrl_t    i_d_ctrl,
   input  lc4_pkg::ctrl_t    i_x_ctrl,
   input  lc4_pkg::ctrl_t    i_m_ctrl,
   input  lc4_pkg::ctrl_t    i_w_ctrl,
   input  logic              i_taken,
   output lc4_pkg::fwd_sel_t o_fwd_a,
   output lc4_pkg::fwd_sel_t o_fwd_b,
   output logic              o_stall,
   output logic              o_flush
);

   // True when a live older instruction writes the given register
   function automatic logic writes(input lc4_pkg::ctrl_t c, input lc4_pkg::reg_idx_t src);
      return c.valid && c.rd_we && (c.rd == src);
   endfunction

   logic load_hit;

   // Memory is younger than Writeback, so it wins
   assign o_fwd_a = !i_x_ctrl.rs_re              ? lc4_pkg::FWD_REG :
                    writes(i_m_ctrl, i_x_ctrl.rs) ? lc4_pkg::FWD_M   :
                    writes(i_w_ctrl, i_x_ctrl.rs) ? lc4_pkg::FWD_W   : lc4_pkg::FWD_REG;
   assign o_fwd_b = !i_x_ctrl.rt_re              ? lc4_pkg::FWD_REG :
                    writes(i_m_ctrl, i_x_ctrl.rt) ? lc4_pkg::FWD_M   :
                    writes(i_w_ctrl, i_x_ctrl.rt) ? lc4_pkg::FWD_W   : lc4_pkg::FWD_REG;

   // Either Decode operand waiting on a load in Execute
   assign load_hit = i_x_ctrl.is_load &&
                     ((i_d_ctrl.rs_re && writes(i_x_ctrl, i_d_ctrl.rs)) ||
                      (i_d_ctrl.rt_re && writes(i_x_ctrl, i_d_ctrl.rt)));

   // A taken branch squashes the consumer anyway
   assign o_stall = load_hit && !i_taken;
   assign o_flush = i_taken;

endmodule

/* lc4_stage_reg.sv */
// Pipeline latch for any stage payload
// Holds on stall, clears to a bubble on flush
`timescale 1ns/10ps

module lc4_stage_reg #(
   parameter type T_PAYLOAD = logic [15:0]
) (
   input  logic     clk,
   input  logic     i_arst_n,
   input  logic     i_hold,
   input  logic     i_flush,
   input  T_PAYLOAD i_d,
   output T_PAYLOAD o_q
);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_q <= '0;
      end else if (i_flush) begin
         // All zero leaves valid and every enable low
         o_q <= '0;
      end else if (!i_hold) begin
         o_q <= i_d;
      end
   end

endmodule

/* lc4_alu.sv */
// LC4 Execute datapath
// Add result, load/store effective address, CONST value and branch target
`timescale 1ns/10ps

module lc4_alu (
   input  lc4_pkg::word_t i_insn,
   input  lc4_pkg::word_t i_pc,
   input  lc4_pkg::word_t i_a,
   input  lc4_pkg::word_t i_b,
   output lc4_pkg::word_t o_result
);

   lc4_pkg::word_t imm5;
   lc4_pkg::word_t imm6;
   lc4_pkg::word_t imm9;

   // Sign-extended immediates
   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      case (i_insn[15:12])
         lc4_pkg::OP_ADD:   o_result = i_insn[5] ? i_a + imm5 : i_a + i_b;
         lc4_pkg::OP_CONST: o_result = imm9;
         lc4_pkg::OP_LDR,
         lc4_pkg::OP_STR:   o_result = i_a + imm6;
         // Target relative to the next PC
         lc4_pkg::OP_BR:    o_result = i_pc + 16'd1 + imm9;
         default:           o_result = '0;
      endcase
   end

endmodule

/* lc4_regfile.sv */
// LC4 register file
// Eight 16-bit registers, two read ports and one write port.
// A same-cycle write is passed straight to the readers
`timescale 1ns/10ps

module lc4_regfile (
   input  logic              clk,
   input  logic              i_arst_n,
   input  lc4_pkg::reg_idx_t i_rs,
   input  lc4_pkg::reg_idx_t i_rt,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data,
   input  lc4_pkg::reg_idx_t i_rd,
   input  logic              i_rd_we,
   input  lc4_pkg::word_t    i_rd_data
);

   lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         regs <= '{default: '0};
      end else if (i_rd_we) begin
         regs[i_rd] <= i_rd_data;
      end
   end

   // Writeback to Decode bypass
   assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_rd_data : regs[i_rs];
   assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_rd_data : regs[i_rt];

endmodule

/* lc4_decoder.sv */
// LC4 instruction decoder
// Turns a 16-bit instruction into source, destination and flag controls.
// Only ADD, CONST, LDR, STR and BR set any enable; the rest decode as no-ops
`timescale 1ns/10ps

module lc4_decoder (
   input  lc4_pkg::word_t i_insn,
   output lc4_pkg::ctrl_t o_ctrl
);

   logic [3:0] opcode;

   assign opcode = i_insn[15:12];

   always_comb begin
      // Field positions common to most formats
      o_ctrl       = '0;
      o_ctrl.valid = 1'b1;
      o_ctrl.rs    = i_insn[8:6];
      o_ctrl.rt    = i_insn[2:0];
      o_ctrl.rd    = i_insn[11:9];

      case (opcode)
         lc4_pkg::OP_ADD: begin
            // Register form needs sub-op 000, imm5 form has bit 5 set
            if (i_insn[5]) begin
               o_ctrl.rs_re  = 1'b1;
               o_ctrl.rd_we  = 1'b1;
               o_ctrl.nzp_we = 1'b1;
            end else if (i_insn[4:3] == 2'b00) begin
               o_ctrl.rs_re  = 1'b1;
               o_ctrl.rt_re  = 1'b1;
               o_ctrl.rd_we  = 1'b1;
               o_ctrl.nzp_we = 1'b1;
            end
         end
         lc4_pkg::OP_CONST: begin
            o_ctrl.rd_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
         end
         lc4_pkg::OP_LDR: begin
            o_ctrl.rs_re   = 1'b1;
            o_ctrl.rd_we   = 1'b1;
            o_ctrl.is_load = 1'b1;
         end
         lc4_pkg::OP_STR: begin
            // Store data register sits in the rd slot
            o_ctrl.rt       = i_insn[11:9];
            o_ctrl.rs_re    = 1'b1;
            o_ctrl.rt_re    = 1'b1;
            o_ctrl.is_store = 1'b1;
         end
         lc4_pkg::OP_BR: begin
            // Mask 000 never resolves taken
            o_ctrl.is_branch = 1'b1;
         end
         default: begin
            // Unsupported, retires with no effect
         end
      endcase
   end

endmodule

/* lc4_pkg.sv */
// LC4 pipeline shared definitions
// Widths, opcodes, reset PC, decoded control and the per-stage payloads
// that travel between pipeline latches and out of the core
package lc4_pkg;

   localparam int WORD_W   = 16;
   localparam int REG_W    = 3;
   localparam int NUM_REGS = 8;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_W-1:0]  reg_idx_t;

   localparam word_t RESET_PC = 16'h8200;

   // Opcode field, insn[15:12]
   localparam logic [3:0] OP_BR    = 4'b0000;
   localparam logic [3:0] OP_ADD   = 4'b0001;
   localparam logic [3:0] OP_LDR   = 4'b0110;
   localparam logic [3:0] OP_STR   = 4'b0111;
   localparam logic [3:0] OP_CONST = 4'b1001;

   // Same bit order as the BR mask in insn[11:9]
   typedef struct packed {
      logic n;
      logic z;
      logic p;
   } nzp_t;

   // All zero is a bubble
   typedef struct packed {
      logic     valid;
      reg_idx_t rs;
      logic     rs_re;
      reg_idx_t rt;
      logic     rt_re;
      reg_idx_t rd;
      logic     rd_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
   } ctrl_t;

   // Fetch to Decode
   typedef struct packed {
      logic  valid;
      word_t pc;
      word_t insn;
   } fd_t;

   // Decode to Execute
   typedef struct packed {
      word_t pc;
      word_t insn;
      ctrl_t ctrl;
      word_t rs_data;
      word_t rt_data;
   } dx_t;

   // Execute to Memory
   typedef struct packed {
      word_t pc;
      word_t insn;
      ctrl_t ctrl;
      word_t result;
      word_t st_data;
      nzp_t  nzp;
   } xm_t;

   // Memory to Writeback, adds the loaded word
   typedef struct packed {
      word_t pc;
      word_t insn;
      ctrl_t ctrl;
      word_t result;
      word_t st_data;
      nzp_t  nzp;
      word_t ld_data;
   } mw_t;

   // Operand source in Execute
   typedef enum logic [1:0] {
      FWD_REG,
      FWD_M,
      FWD_W
   } fwd_sel_t;

   typedef struct packed {
      logic  we;
      word_t addr;
      word_t wdata;
   } dmem_req_t;

   // One record per retired instruction
   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     rd_we;
      reg_idx_t rd;
      word_t    rd_data;
      logic     nzp_we;
      nzp_t     nzp;
   } commit_t;

endpackage
